/* fe_addr_pkg.sv */
package fe_addr_pkg;

   localparam int vaddr_width_gp       = 32;
   localparam int page_offset_width_gp = 12;
   localparam int vtag_width_gp        = vaddr_width_gp - page_offset_width_gp;
   localparam int ptag_width_gp        = 20;
   localparam int instr_width_gp       = 32;

   typedef logic [vaddr_width_gp-1:0] vaddr_t;
   typedef logic [vtag_width_gp-1:0]  vtag_t;
   typedef logic [ptag_width_gp-1:0]  ptag_t;
   typedef logic [instr_width_gp-1:0] instr_t;

   // first dram page, pages below it belong to the tile
   localparam ptag_t dram_base_ptag_gp = 20'h00010;

   // upper half of the physical space is the uncached io region
   function automatic logic ptag_uncached(ptag_t ptag);
      return ptag[ptag_width_gp-1];
   endfunction

   function automatic logic ptag_local(ptag_t ptag);
      return ptag < dram_base_ptag_gp;
   endfunction

   function automatic vtag_t vaddr_vtag(vaddr_t vaddr);
      return vaddr[vaddr_width_gp-1:page_offset_width_gp];
   endfunction

endpackage

/* fe_op_pkg.sv */
package fe_op_pkg;

   // front end memory commands
   typedef enum logic [2:0] {
      e_op_fetch        = 3'd0,
      e_op_tlb_fill     = 3'd1,
      e_op_tlb_fence    = 3'd2,
      e_op_icache_fill  = 3'd3,
      e_op_icache_fence = 3'd4
   } fe_op_e;

   // risc-v privilege encoding, 2 is reserved
   typedef enum logic [1:0] {
      e_priv_u = 2'd0,
      e_priv_s = 2'd1,
      e_priv_m = 2'd3
   } priv_e;

endpackage

/* fe_stage_if.sv */
`timescale 1ns/1ps

// decoded command, one strobe per accepted command
interface fe_cmd_if;
   import fe_addr_pkg::*;

   logic   fetch_v;
   logic   tlb_fill_v;
   logic   tlb_fence_v;
   logic   icache_fill_v;
   logic   icache_fence_v;
   vaddr_t vaddr;
   ptag_t  fill_ptag;
   logic   fill_u;
   logic   fill_x;
   instr_t fill_instr;
   logic   advance;       // pipeline moves this cycle

   modport drv (output fetch_v, tlb_fill_v, tlb_fence_v, icache_fill_v, icache_fence_v,
                output vaddr, fill_ptag, fill_u, fill_x, fill_instr, advance);
   modport rcv (input fetch_v, tlb_fill_v, tlb_fence_v, icache_fill_v, icache_fence_v,
                input vaddr, fill_ptag, fill_u, fill_x, fill_instr, advance);
endinterface

// stage 1 translation result
interface fe_xlate_if;
   import fe_addr_pkg::*;

   logic  ptag_v;
   ptag_t ptag;
   logic  u;
   logic  x;
   logic  miss;

   modport drv (output ptag_v, ptag, u, x, miss);
   modport rcv (input ptag_v, ptag, u, x, miss);
endinterface

/* fe_cmd_decode.sv */
`timescale 1ns/1ps

module fe_cmd_decode (
   input  logic                clk_i,
   input  logic                reset_i,
   input  logic                cmd_v_i,
   output logic                cmd_ready_o,
   input  fe_op_pkg::fe_op_e   cmd_op_i,
   input  fe_addr_pkg::vaddr_t cmd_vaddr_i,
   input  fe_addr_pkg::ptag_t  cmd_ptag_i,
   input  logic                cmd_u_i,
   input  logic                cmd_x_i,
   input  fe_addr_pkg::instr_t cmd_instr_i,
   input  logic                resp_v_i,
   input  logic                resp_ready_i,
   fe_cmd_if.drv               cmd_o
);

   import fe_op_pkg::*;

   logic advance;
   logic accept;

   // only an unconsumed response stalls the pipe
   assign advance     = ~resp_v_i | resp_ready_i;
   assign cmd_ready_o = advance;
   assign accept      = cmd_v_i & advance;

   assign cmd_o.advance        = advance;
   assign cmd_o.fetch_v        = accept & (cmd_op_i == e_op_fetch);
   assign cmd_o.tlb_fill_v     = accept & (cmd_op_i == e_op_tlb_fill);
   assign cmd_o.tlb_fence_v    = accept & (cmd_op_i == e_op_tlb_fence);
   assign cmd_o.icache_fill_v  = accept & (cmd_op_i == e_op_icache_fill);
   assign cmd_o.icache_fence_v = accept & (cmd_op_i == e_op_icache_fence);

   // payload goes straight through and consumers qualify it with the strobes
   assign cmd_o.vaddr      = cmd_vaddr_i;
   assign cmd_o.fill_ptag  = cmd_ptag_i;
   assign cmd_o.fill_u     = cmd_u_i;
   assign cmd_o.fill_x     = cmd_x_i;
   assign cmd_o.fill_instr = cmd_instr_i;

   a_strobe_onehot : assert property (@(posedge clk_i) disable iff (reset_i)
      accept |-> $onehot({cmd_o.fetch_v, cmd_o.tlb_fill_v, cmd_o.tlb_fence_v,
                          cmd_o.icache_fill_v, cmd_o.icache_fence_v}));

endmodule

/* fe_itlb.sv */
`timescale 1ns/1ps

module fe_itlb #(
   parameter int tlb_els_p = 4
) (
   input  logic    clk_i,
   input  logic    reset_i,
   input  logic    translation_en_i,
   fe_cmd_if.rcv   cmd_i,
   fe_xlate_if.drv xlate_o
);

   import fe_addr_pkg::*;

   localparam int ptr_width_lp = $clog2(tlb_els_p);

   logic [tlb_els_p-1:0]    entry_v_r;
   vtag_t                   entry_vtag_r [tlb_els_p];
   ptag_t                   entry_ptag_r [tlb_els_p];
   logic [tlb_els_p-1:0]    entry_u_r;
   logic [tlb_els_p-1:0]    entry_x_r;
   logic [ptr_width_lp-1:0] fill_ptr_r;   // round-robin victim

   vtag_t                cmd_vtag;
   logic [tlb_els_p-1:0] match;
   logic                 match_any;
   ptag_t                match_ptag;
   logic                 match_u;
   logic                 match_x;

   assign cmd_vtag = vaddr_vtag(cmd_i.vaddr);

   // cam lookup, entries are one-hot so an or-merge selects
   always_comb begin
      match_ptag = '0;
      match_u    = 1'b0;
      match_x    = 1'b0;
      for (int i = 0; i < tlb_els_p; i++) begin
         match[i] = entry_v_r[i] & (entry_vtag_r[i] == cmd_vtag);
         if (match[i]) begin
            match_ptag = match_ptag | entry_ptag_r[i];
            match_u    = match_u | entry_u_r[i];
            match_x    = match_x | entry_x_r[i];
         end
      end
   end

   assign match_any = |match;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         entry_v_r  <= '0;
         fill_ptr_r <= '0;
      end else if (cmd_i.tlb_fence_v) begin
         entry_v_r <= '0;
      end else if (cmd_i.tlb_fill_v) begin
         entry_v_r[fill_ptr_r] <= 1'b1;
         fill_ptr_r <= (fill_ptr_r == ptr_width_lp'(tlb_els_p - 1)) ? '0 : fill_ptr_r + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (cmd_i.tlb_fill_v) begin
         entry_vtag_r[fill_ptr_r] <= cmd_vtag;
         entry_ptag_r[fill_ptr_r] <= cmd_i.fill_ptag;
         entry_u_r[fill_ptr_r]    <= cmd_i.fill_u;
         entry_x_r[fill_ptr_r]    <= cmd_i.fill_x;
      end
   end

   // stage 1 result, held while the pipe is stalled
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         xlate_o.ptag_v <= 1'b0;
         xlate_o.miss   <= 1'b0;
      end else if (cmd_i.fetch_v) begin
         xlate_o.ptag_v <= ~translation_en_i | match_any;
         xlate_o.miss   <= translation_en_i & ~match_any;
      end
   end

   always_ff @(posedge clk_i) begin
      if (cmd_i.fetch_v) begin
         xlate_o.ptag <= translation_en_i ? match_ptag : ptag_t'(cmd_vtag);  // passthrough
         xlate_o.u    <= translation_en_i & match_u;
         xlate_o.x    <= ~translation_en_i | match_x;
      end
   end

   a_match_onehot : assert property (@(posedge clk_i) disable iff (reset_i)
      cmd_i.fetch_v & translation_en_i |-> $onehot0(match));

endmodule

/* fe_icache.sv */
`timescale 1ns/1ps

module fe_icache #(
   parameter int sets_p = 64
) (
   input  logic                clk_i,
   input  logic                reset_i,
   fe_cmd_if.rcv               cmd_i,
   fe_xlate_if.rcv             xlate_i,
   output logic                hit_o,
   output fe_addr_pkg::instr_t instr_o
);

   import fe_addr_pkg::*;

   localparam int index_width_lp = $clog2(sets_p);
   localparam int index_lsb_lp   = 2;   // word aligned fetches

   logic [sets_p-1:0] line_v_r;
   ptag_t             tag_mem  [sets_p];
   instr_t            data_mem [sets_p];

   logic [index_width_lp-1:0] index;

   // stage 1 read of the indexed line
   logic   rd_v_r;
   ptag_t  rd_tag_r;
   instr_t rd_data_r;

   // index lies inside the page offset, so vaddr is good enough
   assign index = cmd_i.vaddr[index_lsb_lp +: index_width_lp];

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         line_v_r <= '0;
         rd_v_r   <= 1'b0;
      end else begin
         if (cmd_i.icache_fence_v) begin
            line_v_r <= '0;
         end else if (cmd_i.icache_fill_v) begin
            line_v_r[index] <= 1'b1;
         end
         if (cmd_i.fetch_v) begin
            rd_v_r <= line_v_r[index];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (cmd_i.icache_fill_v) begin
         tag_mem[index]  <= cmd_i.fill_ptag;
         data_mem[index] <= cmd_i.fill_instr;
      end
   end

   always_ff @(posedge clk_i) begin
      if (cmd_i.fetch_v) begin
         rd_tag_r  <= tag_mem[index];
         rd_data_r <= data_mem[index];
      end
   end

   // uncached pages never hit, even with a matching stale tag
   assign hit_o = xlate_i.ptag_v
                & ~ptag_uncached(xlate_i.ptag)
                & rd_v_r
                & (rd_tag_r == xlate_i.ptag);

   assign instr_o = rd_data_r;

endmodule

/* fe_resp_stage.sv */
`timescale 1ns/1ps

module fe_resp_stage (
   input  logic                clk_i,
   input  logic                reset_i,
   input  fe_op_pkg::priv_e    priv_i,
   input  logic                translation_en_i,
   input  logic                uncached_mode_i,
   input  logic                poison_i,
   fe_cmd_if.rcv               cmd_i,
   fe_xlate_if.rcv             xlate_i,
   input  logic                hit_i,
   input  fe_addr_pkg::instr_t instr_i,
   output logic                resp_v_o,
   input  logic                resp_ready_i,
   output logic                resp_access_fault_o,
   output logic                resp_page_fault_o,
   output logic                resp_itlb_miss_o,
   output logic                resp_icache_miss_o,
   output fe_addr_pkg::instr_t resp_instr_o
);

   import fe_addr_pkg::*;
   import fe_op_pkg::*;

   logic s1_v_r;
   logic local_fault;
   logic mode_fault;
   logic access_fault;
   logic priv_fault;
   logic page_fault;

   // no speculative fetch from tile memory
   assign local_fault  = ptag_local(xlate_i.ptag);
   assign mode_fault   = uncached_mode_i & ~ptag_uncached(xlate_i.ptag);
   assign access_fault = xlate_i.ptag_v & (local_fault | mode_fault);

   // s-mode may not run user pages, u-mode only runs user pages
   assign priv_fault = ((priv_i == e_priv_s) & xlate_i.u)
                     | ((priv_i == e_priv_u) & ~xlate_i.u);
   assign page_fault = translation_en_i & xlate_i.ptag_v & (priv_fault | ~xlate_i.x);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         s1_v_r   <= 1'b0;
         resp_v_o <= 1'b0;
      end else if (cmd_i.advance) begin
         s1_v_r   <= cmd_i.fetch_v;
         resp_v_o <= s1_v_r & ~poison_i;   // poison kills the stage 1 fetch
      end
   end

   always_ff @(posedge clk_i) begin
      if (cmd_i.advance) begin
         resp_access_fault_o <= access_fault;
         resp_page_fault_o   <= page_fault;
         resp_itlb_miss_o    <= xlate_i.miss;
         resp_icache_miss_o  <= ~hit_i;
         resp_instr_o        <= (hit_i & ~access_fault & ~page_fault) ? instr_i : '0;
      end
   end

   a_resp_stable : assert property (@(posedge clk_i) disable iff (reset_i)
      resp_v_o & ~resp_ready_i |=> resp_v_o
         & $stable({resp_access_fault_o, resp_page_fault_o, resp_itlb_miss_o,
                    resp_icache_miss_o, resp_instr_o}));

endmodule

/* fe_mem_top.sv */
`timescale 1ns/1ps

module fe_mem_top #(
   parameter int tlb_els_p = 4,
   parameter int sets_p    = 64
) (
   input  logic                clk_i,
   input  logic                reset_i,

   input  logic                cmd_v_i,
   output logic                cmd_ready_o,
   input  fe_op_pkg::fe_op_e   cmd_op_i,
   input  fe_addr_pkg::vaddr_t cmd_vaddr_i,
   input  fe_addr_pkg::ptag_t  cmd_ptag_i,
   input  logic                cmd_u_i,
   input  logic                cmd_x_i,
   input  fe_addr_pkg::instr_t cmd_instr_i,

   input  fe_op_pkg::priv_e    priv_i,
   input  logic                translation_en_i,
   input  logic                uncached_mode_i,
   input  logic                poison_i,

   output logic                resp_v_o,
   input  logic                resp_ready_i,
   output logic                resp_access_fault_o,
   output logic                resp_page_fault_o,
   output logic                resp_itlb_miss_o,
   output logic                resp_icache_miss_o,
   output fe_addr_pkg::instr_t resp_instr_o
);

   import fe_addr_pkg::*;

   fe_cmd_if   cmd_if ();
   fe_xlate_if xlate_if ();

   logic   icache_hit;
   instr_t icache_instr;

   fe_cmd_decode u_decode (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .cmd_v_i      (cmd_v_i),
      .cmd_ready_o  (cmd_ready_o),
      .cmd_op_i     (cmd_op_i),
      .cmd_vaddr_i  (cmd_vaddr_i),
      .cmd_ptag_i   (cmd_ptag_i),
      .cmd_u_i      (cmd_u_i),
      .cmd_x_i      (cmd_x_i),
      .cmd_instr_i  (cmd_instr_i),
      .resp_v_i     (resp_v_o),     // stall source
      .resp_ready_i (resp_ready_i),
      .cmd_o        (cmd_if.drv)
   );

   fe_itlb #(.tlb_els_p(tlb_els_p)) u_itlb (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .translation_en_i (translation_en_i),
      .cmd_i            (cmd_if.rcv),
      .xlate_o          (xlate_if.drv)
   );

   fe_icache #(.sets_p(sets_p)) u_icache (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .cmd_i   (cmd_if.rcv),
      .xlate_i (xlate_if.rcv),
      .hit_o   (icache_hit),
      .instr_o (icache_instr)
   );

   fe_resp_stage u_resp (
      .clk_i               (clk_i),
      .reset_i             (reset_i),
      .priv_i              (priv_i),
      .translation_en_i    (translation_en_i),
      .uncached_mode_i     (uncached_mode_i),
      .poison_i            (poison_i),
      .cmd_i               (cmd_if.rcv),
      .xlate_i             (xlate_if.rcv),
      .hit_i               (icache_hit),
      .instr_i             (icache_instr),
      .resp_v_o            (resp_v_o),
      .resp_ready_i        (resp_ready_i),
      .resp_access_fault_o (resp_access_fault_o),
      .resp_page_fault_o   (resp_page_fault_o),
      .resp_itlb_miss_o    (resp_itlb_miss_o),
      .resp_icache_miss_o  (resp_icache_miss_o),
      .resp_instr_o        (resp_instr_o)
   );

endmodule

/* tb_fe_mem_ref.svh */
typedef struct packed {
   logic   access_fault;
   logic   page_fault;
   logic   itlb_miss;
   logic   icache_miss;
   instr_t instr;
} resp_t;

// mirror of the itlb and icache updated at the accepting edge of each command
logic   ref_tlb_v    [tlb_els_lp];
vtag_t  ref_tlb_vtag [tlb_els_lp];
ptag_t  ref_tlb_ptag [tlb_els_lp];
logic   ref_tlb_u    [tlb_els_lp];
logic   ref_tlb_x    [tlb_els_lp];
int     ref_tlb_ptr;
logic   ref_line_v    [sets_lp];
ptag_t  ref_line_tag  [sets_lp];
instr_t ref_line_data [sets_lp];

function automatic int line_of(vaddr_t vaddr);
   return int'((vaddr >> 2) % sets_lp);
endfunction

function automatic logic tlb_holds(vtag_t vtag);
   foreach (ref_tlb_v[i]) begin
      if (ref_tlb_v[i] && ref_tlb_vtag[i] == vtag) return 1'b1;
   end
   return 1'b0;
endfunction

task automatic clear_mirror();
   foreach (ref_tlb_v[i]) ref_tlb_v[i] = 1'b0;
   foreach (ref_line_v[i]) ref_line_v[i] = 1'b0;
   ref_tlb_ptr = 0;
endtask

task automatic update_mirror(input fe_op_e op, input vaddr_t vaddr, input ptag_t ptag,
                             input logic u, input logic x, input instr_t instr);
   case (op)
      e_op_tlb_fill: begin
         ref_tlb_v[ref_tlb_ptr]    = 1'b1;
         ref_tlb_vtag[ref_tlb_ptr] = vaddr[31:12];
         ref_tlb_ptag[ref_tlb_ptr] = ptag;
         ref_tlb_u[ref_tlb_ptr]    = u;
         ref_tlb_x[ref_tlb_ptr]    = x;
         ref_tlb_ptr = (ref_tlb_ptr + 1) % tlb_els_lp;   // round robin
      end
      e_op_tlb_fence:    foreach (ref_tlb_v[i]) ref_tlb_v[i] = 1'b0;
      e_op_icache_fill: begin
         ref_line_v[line_of(vaddr)]    = 1'b1;
         ref_line_tag[line_of(vaddr)]  = ptag;
         ref_line_data[line_of(vaddr)] = instr;
      end
      e_op_icache_fence: foreach (ref_line_v[i]) ref_line_v[i] = 1'b0;
      default: ;
   endcase
endtask

// expected response of a fetch from the mirror and the current context
function automatic resp_t predict_fetch(vaddr_t vaddr);
   resp_t r;
   logic  ptag_v;
   ptag_t ptag;
   logic  u;
   logic  x;
   logic  hit;
   ptag_v = !translation_en_i;
   ptag   = vaddr[31:12];
   u      = 1'b0;
   x      = 1'b1;
   foreach (ref_tlb_v[i]) begin
      if (translation_en_i && ref_tlb_v[i] && ref_tlb_vtag[i] == vaddr[31:12]) begin
         ptag_v = 1'b1;
         ptag   = ref_tlb_ptag[i];
         u      = ref_tlb_u[i];
         x      = ref_tlb_x[i];
      end
   end
   hit = ptag_v && !ptag[19] && ref_line_v[line_of(vaddr)]
         && ref_line_tag[line_of(vaddr)] == ptag;
   r.itlb_miss    = translation_en_i && !ptag_v;
   r.icache_miss  = !hit;
   r.access_fault = ptag_v && (ptag < dram_base_ptag_gp || (uncached_mode_i && !ptag[19]));
   r.page_fault   = translation_en_i && ptag_v
                  && ((priv_i == e_priv_s && u) || (priv_i == e_priv_u && !u) || !x);
   r.instr = (hit && !r.access_fault && !r.page_fault) ? ref_line_data[line_of(vaddr)] : '0;
   return r;
endfunction

/* tb_fe_mem_top.sv */
`timescale 1ns/1ps

module tb_fe_mem_top;

   import fe_addr_pkg::*;
   import fe_op_pkg::*;

   localparam int tlb_els_lp = 4;
   localparam int sets_lp    = 64;
   localparam int timeout_lp = 100;   // cycles allowed per wait

   logic   clk_i, reset_i;
   logic   cmd_v_i, cmd_ready_o, cmd_u_i, cmd_x_i;
   fe_op_e cmd_op_i;
   vaddr_t cmd_vaddr_i;
   ptag_t  cmd_ptag_i;
   instr_t cmd_instr_i, resp_instr_o;
   priv_e  priv_i;
   logic   translation_en_i, uncached_mode_i, poison_i;
   logic   resp_v_o, resp_ready_i, resp_access_fault_o, resp_page_fault_o;
   logic   resp_itlb_miss_o, resp_icache_miss_o;

   integer seed;
   int     mismatch_count, other_errors, resp_count, accept_count;
   logic   timed_out;
   logic   bp_en;   // random back-pressure on the response

   `include "tb_fe_mem_ref.svh"

   resp_t exp_q [$];
   resp_t head;
   resp_t s1_exp;
   logic  s1_v;   // a predicted fetch sits in stage 1

   fe_mem_top #(.tlb_els_p(tlb_els_lp), .sets_p(sets_lp)) DUT (.*);

   always #50 clk_i = ~clk_i;

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         mismatch_count++;
         $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   // consumed responses are compared before stage 1 moves on
   always @(posedge clk_i) begin
      if (reset_i) begin
         clear_mirror();
         exp_q.delete();
         s1_v = 1'b0;
      end else begin
         if (resp_v_o && resp_ready_i) begin
            resp_count++;
            if (exp_q.size() == 0) begin
               other_errors++;
               $display("response at %0t ns arrived with no fetch outstanding", $time);
            end else begin
               head = exp_q.pop_front();
               check_value("resp_access_fault_o", resp_access_fault_o, head.access_fault);
               check_value("resp_page_fault_o", resp_page_fault_o, head.page_fault);
               check_value("resp_itlb_miss_o", resp_itlb_miss_o, head.itlb_miss);
               check_value("resp_icache_miss_o", resp_icache_miss_o, head.icache_miss);
               check_value("resp_instr_o", resp_instr_o, head.instr);
            end
         end
         if (cmd_ready_o) begin
            if (s1_v && !poison_i) exp_q.push_back(s1_exp);
            s1_v = 1'b0;
         end
         if (cmd_v_i && cmd_ready_o) begin
            accept_count++;
            if (cmd_op_i == e_op_fetch) begin
               s1_v   = 1'b1;
               s1_exp = predict_fetch(cmd_vaddr_i);
            end
            update_mirror(cmd_op_i, cmd_vaddr_i, cmd_ptag_i, cmd_u_i, cmd_x_i, cmd_instr_i);
         end
      end
   end

   task automatic report_timeout(input string what);
      timed_out = 1'b1;
      other_errors++;
      $display("no progress within %0d cycles while waiting for %s", timeout_lp, what);
   endtask

   // called and returns at a falling edge
   task automatic send_cmd(input fe_op_e op, input vaddr_t vaddr, input ptag_t ptag,
                           input logic u, input logic x, input instr_t instr, input logic poison);
      int count0;
      int waited;
      if (!timed_out) begin
         cmd_v_i     = 1'b1;
         cmd_op_i    = op;
         cmd_vaddr_i = vaddr;
         cmd_ptag_i  = ptag;
         cmd_u_i     = u;
         cmd_x_i     = x;
         cmd_instr_i = instr;
         poison_i    = poison;
         count0 = accept_count;
         waited = 0;
         while (accept_count == count0 && waited < timeout_lp) begin
            @(negedge clk_i);
            waited++;
            if (bp_en) resp_ready_i = 1'($random(seed));
         end
         cmd_v_i  = 1'b0;
         poison_i = 1'b0;
         if (accept_count == count0) report_timeout("command accept");
      end
   endtask

   task automatic fetch(input vaddr_t vaddr);
      send_cmd(e_op_fetch, vaddr, '0, 1'b0, 1'b0, '0, 1'b0);
   endtask

   task automatic tlb_fill(input vtag_t vtag, input ptag_t ptag, input logic u, input logic x);
      send_cmd(e_op_tlb_fill, {vtag, 12'h000}, ptag, u, x, '0, 1'b0);
   endtask

   task automatic icache_fill(input vaddr_t vaddr, input ptag_t ptag, input instr_t instr);
      send_cmd(e_op_icache_fill, vaddr, ptag, 1'b0, 1'b0, instr, 1'b0);
   endtask

   task automatic drain_pipe();
      int waited;
      waited = 0;
      cmd_v_i      = 1'b0;
      resp_ready_i = 1'b1;
      while (!timed_out && (exp_q.size() != 0 || s1_v || resp_v_o)) begin
         @(negedge clk_i);
         waited++;
         if (waited >= timeout_lp) report_timeout("outstanding responses");
      end
   endtask

   task automatic set_context(input priv_e priv, input logic xlate, input logic uncached);
      drain_pipe();
      priv_i           = priv;
      translation_en_i = xlate;
      uncached_mode_i  = uncached;
   endtask

   task automatic cache_fill_and_fence();
      set_context(e_priv_m, 1'b0, 1'b0);
      icache_fill(32'h0002_0040, 20'h00020, 32'h1234_abcd);
      fetch(32'h0002_0040);
      fetch(32'h0000_3040);   // tile memory on the same line
      send_cmd(e_op_icache_fence, '0, '0, 1'b0, 1'b0, '0, 1'b0);
      fetch(32'h0002_0040);
   endtask

   task automatic tlb_eviction();
      set_context(e_priv_m, 1'b1, 1'b0);
      fetch(32'h4000_0010);
      for (int i = 0; i <= tlb_els_lp; i++)
         tlb_fill(20'h40000 + 20'(i), 20'h00100 + 20'(i), 1'b0, 1'b1);
      icache_fill(32'h4000_4010, 20'h00104, 32'h0bad_f00d);
      for (int i = 0; i <= tlb_els_lp; i++) fetch({20'h40000 + 20'(i), 12'h010});
      send_cmd(e_op_tlb_fence, '0, '0, 1'b0, 1'b0, '0, 1'b0);
      fetch(32'h4000_2010);
   endtask

   task automatic fault_matrix();
      priv_e privs [3] = '{e_priv_u, e_priv_s, e_priv_m};
      set_context(e_priv_m, 1'b1, 1'b0);
      tlb_fill(20'h50000, 20'h00200, 1'b1, 1'b1);   // user page
      tlb_fill(20'h50001, 20'h00201, 1'b0, 1'b1);
      tlb_fill(20'h50002, 20'h00202, 1'b0, 1'b0);   // not executable
      tlb_fill(20'h50003, 20'h00005, 1'b0, 1'b1);   // tile memory
      for (int i = 0; i < 4; i++)
         icache_fill({20'h50000 + 20'(i), 12'h020 + 12'(4 * i)},
                     (i == 3) ? 20'h00005 : 20'h00200 + 20'(i), 32'hc0de_0000 + i);
      foreach (privs[k]) begin
         set_context(privs[k], 1'b1, 1'b0);
         for (int i = 0; i < 4; i++) fetch({20'h50000 + 20'(i), 12'h020 + 12'(4 * i)});
      end
      set_context(e_priv_m, 1'b1, 1'b1);
      tlb_fill(20'h50004, 20'h80010, 1'b0, 1'b1);   // io page
      fetch(32'h5000_1024);
      fetch(32'h5000_4020);
   endtask

   task automatic poison_drop();
      int n0;
      set_context(e_priv_m, 1'b0, 1'b0);
      icache_fill(32'h0002_0000, 20'h00020, 32'haaaa_0001);
      icache_fill(32'h0002_0004, 20'h00020, 32'hbbbb_0002);
      icache_fill(32'h0002_0008, 20'h00020, 32'hcccc_0003);
      n0 = resp_count;
      fetch(32'h0002_0000);
      fetch(32'h0002_0004);
      send_cmd(e_op_fetch, 32'h0002_0008, '0, 1'b0, 1'b0, '0, 1'b1);   // kills the second
      drain_pipe();
      check_value("resp_v_o count", resp_count - n0, 2);
   endtask

   task automatic random_traffic();
      int     r;
      fe_op_e op;
      vaddr_t va;
      ptag_t  pt;
      logic   u;
      logic   x;
      set_context(e_priv_s, 1'b1, 1'b0);
      bp_en = 1'b1;
      for (int n = 0; n < 300; n++) begin
         r  = $unsigned($random(seed)) % 16;
         va = {20'h00400 + 20'($unsigned($random(seed)) % 6), 8'h00, 2'($random(seed)), 2'b00};
         pt = ($unsigned($random(seed)) % 5 < 3) ? 20'h00100 + 20'(r % 3) : 20'h80100 - 20'(r % 2);
         u  = 1'($random(seed));
         x  = ($unsigned($random(seed)) % 4) != 0;
         if (r < 10) op = e_op_fetch;
         else if (r < 12) op = tlb_holds(va[31:12]) ? e_op_tlb_fence : e_op_tlb_fill;
         else if (r < 13) op = e_op_tlb_fence;
         else if (r < 15) op = e_op_icache_fill;
         else op = e_op_icache_fence;
         if (pt == 20'h800ff) pt = 20'h00008;   // some tile memory too
         send_cmd(op, va, pt, u, x, $random(seed), 1'b0);
         if (($unsigned($random(seed)) % 4) == 0) begin
            @(negedge clk_i);   // idle gap
            resp_ready_i = 1'($random(seed));
         end
      end
      bp_en = 1'b0;
      drain_pipe();
   endtask

   initial begin
      seed             = 31302;
      mismatch_count   = 0;
      other_errors     = 0;
      resp_count       = 0;
      accept_count     = 0;
      timed_out        = 1'b0;
      bp_en            = 1'b0;
      clk_i            = 1'b0;
      reset_i          = 1'b1;
      cmd_v_i          = 1'b0;
      cmd_op_i         = e_op_fetch;
      cmd_vaddr_i      = '0;
      cmd_ptag_i       = '0;
      cmd_u_i          = 1'b0;
      cmd_x_i          = 1'b0;
      cmd_instr_i      = '0;
      priv_i           = e_priv_m;
      translation_en_i = 1'b0;
      uncached_mode_i  = 1'b0;
      poison_i         = 1'b0;
      resp_ready_i     = 1'b1;
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;
      cache_fill_and_fence();
      tlb_eviction();
      fault_matrix();
      poison_drop();
      random_traffic();
      drain_pipe();
      $display("responses: %0d, mismatches: %0d, other errors: %0d",
               resp_count, mismatch_count, other_errors);
      if (mismatch_count == 0 && other_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* fe_mem_top.f */
+incdir+.
fe_addr_pkg.sv
fe_op_pkg.sv
fe_stage_if.sv
fe_cmd_decode.sv
fe_itlb.sv
fe_icache.sv
fe_resp_stage.sv
fe_mem_top.sv
tb_fe_mem_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_fe_mem_top -f fe_mem_top.f -o tb_fe_mem_top
./obj_dir/tb_fe_mem_top | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log || ! grep -q "ALL TESTS PASSED" sim.log; then
   echo "simulation failed, see sim.log"
   exit 1
fi
